// ==== ahb_mailbox_top.f ====
verilog/ahb_mbox_pkg.sv
verilog/ahb_mbox_addr_phase.sv
verilog/ahb_mbox_ram.sv
verilog/ahb_mbox_ctrl_regs.sv
verilog/ahb_mbox_resp.sv
verilog/ahb_mailbox_top.sv
verif/tb_ahb_mailbox.sv

// ==== Makefile ====
# Verilator flow for the AHB-Lite mailbox slave

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f ahb_mailbox_top.f --top-module ahb_mailbox_top

sim:
	verilator --binary --timing --assert -f ahb_mailbox_top.f \
		--top-module tb_ahb_mailbox -o tb_ahb_mailbox
	-./obj_dir/tb_ahb_mailbox 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation passed" $(LOG); then \
		echo "Run FAILED, see $(LOG)"; \
		exit 1; \
	fi
	@echo "Run passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/tb_ahb_mailbox.sv ====
// Testbench for the AHB-Lite mailbox slave
// Runs a table of AHB transfers through the DUT with address and data phases
// pipelined, checking read data, the OKAY/ERROR response and irq_o
`timescale 1ns/1ps

module tb_ahb_mailbox;

localparam int A_WIDTH    = 32;
localparam int RAM_DEPTH  = 1024;
localparam int WAIT_LIMIT = 16;

localparam logic [1:0]  TRANS_IDLE   = 2'b00;
localparam logic [1:0]  TRANS_NONSEQ = 2'b10;
localparam logic [1:0]  RESP_OKAY    = 2'b00;
localparam logic [1:0]  RESP_ERROR   = 2'b01;
localparam logic [2:0]  SIZE_BYTE    = 3'b000;
localparam logic [2:0]  SIZE_HALF    = 3'b001;
localparam logic [2:0]  SIZE_WORD    = 3'b010;
localparam logic [31:0] RAM_BASE     = 32'h0000_8000;  // Bit 15 selects the RAM

logic        hclk;
logic        hresetn;
logic        hsel;
logic [31:0] haddr;
logic [3:0]  hprot;
logic [2:0]  hsize;
logic [1:0]  htrans;
logic [2:0]  hburst;
logic        hwrite;
logic [31:0] hwdata;
logic [1:0]  hresp;
logic        hready;
logic [31:0] hrdata;
logic        irq;

// Transfer table with one element per entry in each queue
string       tbl_name[$];
logic        tbl_write[$];
logic [31:0] tbl_addr[$];
logic [2:0]  tbl_size[$];
logic [31:0] tbl_data[$];
logic [31:0] tbl_rdata[$];
logic [1:0]  tbl_resp[$];
int          tbl_irq[$];  // -1 while irq_o may still be settling
logic        tbl_b2b[$];  // Issued with no idle cycle before it

logic pend_valid;  // An entry is in its data phase
int   pend_idx;

ahb_mailbox_top #(
    .A_WIDTH(A_WIDTH),
    .RAM_DEPTH(RAM_DEPTH)
) i_ahb_mailbox_top (
    .hclk_i(hclk), .hresetn_i(hresetn), .hsel_i(hsel), .haddr_i(haddr),
    .hprot_i(hprot), .hsize_i(hsize), .htrans_i(htrans), .hburst_i(hburst),
    .hwrite_i(hwrite), .hwdata_i(hwdata), .hresp_o(hresp), .hready_o(hready),
    .hrdata_o(hrdata), .irq_o(irq)
);

initial begin
    hclk = 1'b0;
    forever #5 hclk = ~hclk;
end

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first mismatch");
    end
endtask

task automatic add_entry(input string name, input logic write, input logic [31:0] addr,
                         input logic [2:0] size, input logic [31:0] data,
                         input logic [31:0] rdata, input logic [1:0] resp,
                         input int irq_exp, input logic b2b);
    tbl_name.push_back(name);
    tbl_write.push_back(write);
    tbl_addr.push_back(addr);
    tbl_size.push_back(size);
    tbl_data.push_back(data);
    tbl_rdata.push_back(rdata);
    tbl_resp.push_back(resp);
    tbl_irq.push_back(irq_exp);
    tbl_b2b.push_back(b2b);
endtask

task automatic build_table();
    logic [31:0] ram_addr [8];
    logic [31:0] ram_data [8];
    logic [31:0] ctrl0;
    logic [31:0] ctrl1;
    int          base;
    int          k;
    base = int'($urandom % (RAM_DEPTH / 8));  // Eight distinct words in the RAM
    for (k = 0; k < 8; k++) begin
        ram_addr[k] = RAM_BASE | 32'((base * 8 + k) * 4);
        ram_data[k] = $urandom;
    end
    add_entry("reset ctrl0", 1'b0, 32'h00, SIZE_WORD, 32'd0, 32'd0, RESP_OKAY, 0, 1'b0);
    add_entry("reset ctrl1", 1'b0, 32'h04, SIZE_WORD, 32'd0, 32'd0, RESP_OKAY, 0, 1'b0);
    for (k = 0; k < 8; k++) begin
        add_entry($sformatf("ram wr %0d", k), 1'b1, ram_addr[k], SIZE_WORD, ram_data[k],
                  32'd0, RESP_OKAY, 0, 1'b0);
        // Read straight behind the write to the same word
        add_entry($sformatf("ram rd fwd %0d", k), 1'b0, ram_addr[k], SIZE_WORD, 32'd0,
                  ram_data[k], RESP_OKAY, 0, 1'b1);
    end
    for (k = 0; k < 8; k++) begin
        add_entry($sformatf("ram rd %0d", k), 1'b0, ram_addr[k], SIZE_WORD, 32'd0,
                  ram_data[k], RESP_OKAY, 0, 1'b0);
    end
    // Bit 31 of a control word is the interrupt flag
    ctrl0 = $urandom;
    ctrl0[31] = 1'b1;
    add_entry("ctrl0 wr intr", 1'b1, 32'h00, SIZE_WORD, ctrl0, 32'd0, RESP_OKAY, 0, 1'b0);
    add_entry("ctrl0 rd intr", 1'b0, 32'h00, SIZE_WORD, 32'd0, ctrl0, RESP_OKAY, -1, 1'b1);
    add_entry("ctrl1 rd idle", 1'b0, 32'h04, SIZE_WORD, 32'd0, 32'd0, RESP_OKAY, 1, 1'b0);
    ctrl1 = $urandom;
    ctrl1[31] = 1'b1;
    add_entry("ctrl1 wr intr", 1'b1, 32'h04, SIZE_WORD, ctrl1, 32'd0, RESP_OKAY, 1, 1'b0);
    add_entry("ctrl1 rd intr", 1'b0, 32'h04, SIZE_WORD, 32'd0, ctrl1, RESP_OKAY, 1, 1'b1);
    ctrl0 = $urandom;
    ctrl0[31] = 1'b0;
    add_entry("ctrl0 wr clear", 1'b1, 32'h00, SIZE_WORD, ctrl0, 32'd0, RESP_OKAY, 1, 1'b0);
    add_entry("ctrl0 rd clear", 1'b0, 32'h00, SIZE_WORD, 32'd0, ctrl0, RESP_OKAY, 1, 1'b1);
    add_entry("ctrl1 rd still", 1'b0, 32'h04, SIZE_WORD, 32'd0, ctrl1, RESP_OKAY, 1, 1'b0);
    ctrl1 = $urandom;
    ctrl1[31] = 1'b0;
    add_entry("ctrl1 wr clear", 1'b1, 32'h04, SIZE_WORD, ctrl1, 32'd0, RESP_OKAY, 1, 1'b0);
    add_entry("ctrl1 rd clear", 1'b0, 32'h04, SIZE_WORD, 32'd0, ctrl1, RESP_OKAY, -1, 1'b1);
    add_entry("ctrl0 rd irq low", 1'b0, 32'h00, SIZE_WORD, 32'd0, ctrl0, RESP_OKAY, 0, 1'b0);
    add_entry("unmapped wr", 1'b1, 32'h08, SIZE_WORD, $urandom, 32'd0, RESP_OKAY, 0, 1'b0);
    add_entry("unmapped rd", 1'b0, 32'h08, SIZE_WORD, 32'd0, 32'd0, RESP_OKAY, 0, 1'b1);
    add_entry("unmapped rd top", 1'b0, 32'h7ffc, SIZE_WORD, 32'd0, 32'd0, RESP_OKAY, 0, 1'b0);
    // Illegal sizes are each followed by a word transfer held through the stall
    add_entry("ram wr half", 1'b1, ram_addr[0], SIZE_HALF, ~ram_data[0], 32'd0,
              RESP_ERROR, 0, 1'b0);
    add_entry("ram rd after half", 1'b0, ram_addr[0], SIZE_WORD, 32'd0, ram_data[0],
              RESP_OKAY, 0, 1'b1);
    add_entry("ctrl1 wr byte", 1'b1, 32'h04, SIZE_BYTE, 32'hffff_ffff, 32'd0,
              RESP_ERROR, 0, 1'b0);
    add_entry("ctrl1 rd after byte", 1'b0, 32'h04, SIZE_WORD, 32'd0, ctrl1, RESP_OKAY, 0, 1'b1);
    add_entry("ram rd half", 1'b0, ram_addr[1], SIZE_HALF, 32'd0, 32'd0, RESP_ERROR, 0, 1'b0);
    add_entry("ctrl0 rd byte", 1'b0, 32'h00, SIZE_BYTE, 32'd0, 32'd0, RESP_ERROR, 0, 1'b1);
    add_entry("ctrl0 rd final", 1'b0, 32'h00, SIZE_WORD, 32'd0, ctrl0, RESP_OKAY, 0, 1'b0);
endtask

task automatic check_data_phase(input int idx, input int cyc);
    string name;
    name = tbl_name[idx];
    if (tbl_resp[idx] == RESP_ERROR) begin
        // hready low in the first ERROR cycle, high in the second
        check_value({name, " hready"}, (cyc == 0) ? 32'd0 : 32'd1, 32'(hready));
        check_value({name, " hresp"}, 32'(RESP_ERROR), 32'(hresp));
    end else begin
        check_value({name, " hready"}, 32'd1, 32'(hready));
        check_value({name, " hresp"}, 32'(RESP_OKAY), 32'(hresp));
        if (!tbl_write[idx]) begin
            check_value({name, " hrdata"}, tbl_rdata[idx], hrdata);
        end
    end
    if (cyc == 0 && tbl_irq[idx] >= 0) begin
        check_value({name, " irq"}, 32'(tbl_irq[idx]), 32'(irq));
    end
endtask

// Called right after a rising edge; returns on the edge that accepts the address phase
task automatic issue_cycle(input logic active, input int idx);
    int cyc;
    if (active) begin
        htrans <= TRANS_NONSEQ;
        haddr  <= tbl_addr[idx];
        hsize  <= tbl_size[idx];
        hwrite <= tbl_write[idx];
    end else begin
        htrans <= TRANS_IDLE;
        hwrite <= 1'b0;
    end
    if (pend_valid && tbl_write[pend_idx]) begin
        hwdata <= tbl_data[pend_idx];  // Data of the transfer now in its data phase
    end
    cyc = 0;
    @(negedge hclk);
    if (pend_valid) check_data_phase(pend_idx, cyc);
    while (hready !== 1'b1) begin
        if (cyc >= WAIT_LIMIT) begin
            $display("Timeout: hready_o stayed low for %0d cycles", WAIT_LIMIT);
            $display("Simulation failed");
            $fatal(1, "Timeout waiting for hready_o");
        end
        cyc++;
        @(negedge hclk);
        if (pend_valid) check_data_phase(pend_idx, cyc);
    end
    @(posedge hclk);
    pend_valid = active;
    pend_idx   = idx;
endtask

initial begin
    int gap;
    int i;
    void'($urandom(83352));
    hresetn = 1'b0;
    hsel    = 1'b0;
    haddr   = 32'd0;
    hprot   = 4'd0;
    hsize   = SIZE_WORD;
    htrans  = TRANS_IDLE;
    hburst  = 3'd0;
    hwrite  = 1'b0;
    hwdata  = 32'd0;
    pend_valid = 1'b0;
    pend_idx   = 0;
    build_table();
    repeat (5) @(posedge hclk);
    hresetn <= 1'b1;
    @(negedge hclk);
    check_value("reset hready", 32'd1, 32'(hready));
    check_value("reset hresp", 32'(RESP_OKAY), 32'(hresp));
    check_value("reset irq", 32'd0, 32'(irq));
    @(posedge hclk);
    hsel <= 1'b1;
    for (i = 0; i < tbl_name.size(); i++) begin
        gap = tbl_b2b[i] ? 0 : int'($urandom % 3);
        repeat (gap) issue_cycle(1'b0, 0);
        issue_cycle(1'b1, i);
    end
    issue_cycle(1'b0, 0);  // Completes the last data phase
    repeat (2) @(posedge hclk);
    $display("Simulation passed");
    $finish;
end

endmodule

// ==== verilog/ahb_mailbox_top.sv ====
// AHB-Lite mailbox slave, top level
// A host and a remote agent exchange messages through the shared RAM in the
// upper half of the address space and the two control registers below it
`timescale 1ns/1ps

module ahb_mailbox_top #(
    parameter int A_WIDTH   = 32,
    parameter int RAM_DEPTH = 8192
) (
    input  logic                                      hclk_i,
    input  logic                                      hresetn_i,
    input  logic                                      hsel_i,
    input  logic [A_WIDTH-1:0]                        haddr_i,
    input  logic [3:0]                                hprot_i,   // Bus compatibility only
    input  logic [2:0]                                hsize_i,
    input  logic [1:0]                                htrans_i,
    input  logic [2:0]                                hburst_i,  // Bursts run as single words
    input  logic                                      hwrite_i,
    input  logic [ahb_mbox_pkg::mbox_data_width-1:0]  hwdata_i,
    output logic [1:0]                                hresp_o,
    output logic                                      hready_o,
    output logic [ahb_mbox_pkg::mbox_data_width-1:0]  hrdata_o,
    output logic                                      irq_o
);

import ahb_mbox_pkg::*;

logic                       ap_ram_rd;
logic                       ap_reg_rd;
logic [mbox_word_aw-1:0]    ap_word_addr;
logic [mbox_region_bit-1:0] ap_reg_off;
logic                       dp_valid;
logic                       dp_write;
logic                       dp_ram;
logic                       dp_err;
logic [mbox_word_aw-1:0]    dp_word_addr;
logic [mbox_region_bit-1:0] dp_reg_off;
logic [mbox_data_width-1:0] ram_rdata;
logic [mbox_data_width-1:0] reg_rdata;

ahb_mbox_addr_phase #(
    .A_WIDTH(A_WIDTH)
) i_addr_phase (
    .hclk_i(hclk_i), .hresetn_i(hresetn_i), .hsel_i(hsel_i), .haddr_i(haddr_i),
    .htrans_i(htrans_i), .hsize_i(hsize_i), .hwrite_i(hwrite_i), .hready_i(hready_o),
    .ap_ram_rd_o(ap_ram_rd), .ap_reg_rd_o(ap_reg_rd),
    .ap_word_addr_o(ap_word_addr), .ap_reg_off_o(ap_reg_off),
    .dp_valid_o(dp_valid), .dp_write_o(dp_write), .dp_ram_o(dp_ram), .dp_err_o(dp_err),
    .dp_word_addr_o(dp_word_addr), .dp_reg_off_o(dp_reg_off)
);

ahb_mbox_ram #(
    .RAM_DEPTH(RAM_DEPTH)
) i_ram (
    .hclk_i(hclk_i), .dp_valid_i(dp_valid), .dp_write_i(dp_write), .dp_ram_i(dp_ram),
    .dp_err_i(dp_err), .dp_word_addr_i(dp_word_addr), .hwdata_i(hwdata_i),
    .ap_ram_rd_i(ap_ram_rd), .ap_word_addr_i(ap_word_addr), .ram_rdata_o(ram_rdata)
);

ahb_mbox_ctrl_regs i_ctrl_regs (
    .hclk_i(hclk_i), .hresetn_i(hresetn_i), .dp_valid_i(dp_valid), .dp_write_i(dp_write),
    .dp_ram_i(dp_ram), .dp_err_i(dp_err), .dp_reg_off_i(dp_reg_off), .hwdata_i(hwdata_i),
    .ap_reg_rd_i(ap_reg_rd), .ap_reg_off_i(ap_reg_off),
    .reg_rdata_o(reg_rdata), .irq_o(irq_o)
);

ahb_mbox_resp i_resp (
    .hclk_i(hclk_i), .hresetn_i(hresetn_i), .dp_valid_i(dp_valid), .dp_ram_i(dp_ram),
    .dp_err_i(dp_err), .ram_rdata_i(ram_rdata), .reg_rdata_i(reg_rdata),
    .hrdata_o(hrdata_o), .hready_o(hready_o), .hresp_o(hresp_o)
);

endmodule

// ==== verilog/ahb_mbox_resp.sv ====
// Data-phase response of the mailbox slave
// Selects RAM or register read data and answers illegal transfers with
// the two-cycle ERROR response; OKAY transfers never wait
`timescale 1ns/1ps

module ahb_mbox_resp (
    input  logic                                      hclk_i,
    input  logic                                      hresetn_i,
    input  logic                                      dp_valid_i,
    input  logic                                      dp_ram_i,
    input  logic                                      dp_err_i,
    input  logic [ahb_mbox_pkg::mbox_data_width-1:0]  ram_rdata_i,
    input  logic [ahb_mbox_pkg::mbox_data_width-1:0]  reg_rdata_i,
    output logic [ahb_mbox_pkg::mbox_data_width-1:0]  hrdata_o,
    output logic                                      hready_o,
    output logic [1:0]                                hresp_o
);

import ahb_mbox_pkg::*;

logic err_first;
logic err_second_q;  // Second ERROR cycle, hready back high

assign err_first = dp_valid_i && dp_err_i;

always_ff @(posedge hclk_i or negedge hresetn_i) begin
    if (!hresetn_i) begin
        err_second_q <= 1'b0;
    end else begin
        err_second_q <= err_first;
    end
end

assign hready_o = !err_first;
assign hresp_o  = (err_first || err_second_q) ? hresp_error : hresp_okay;

always_comb begin
    hrdata_o = '0;
    if (dp_valid_i && !dp_err_i) begin
        hrdata_o = dp_ram_i ? ram_rdata_i : reg_rdata_i;
    end
end

// The stall is one cycle only; the address phase must not capture a
// new error data phase while hready is low
assert property (@(posedge hclk_i) disable iff (!hresetn_i)
    !hready_o |=> hready_o)
    else $error("hready_o low for two cycles in a row");

endmodule

// ==== verilog/ahb_mbox_ctrl_regs.sv ====
// The two mailbox control registers and the interrupt output
// Registers are written as raw bus words at offsets 0x00 and 0x04 and
// read back in the address phase; other offsets read zero
`timescale 1ns/1ps

module ahb_mbox_ctrl_regs (
    input  logic                                      hclk_i,
    input  logic                                      hresetn_i,
    input  logic                                      dp_valid_i,
    input  logic                                      dp_write_i,
    input  logic                                      dp_ram_i,
    input  logic                                      dp_err_i,
    input  logic [ahb_mbox_pkg::mbox_region_bit-1:0]  dp_reg_off_i,
    input  logic [ahb_mbox_pkg::mbox_data_width-1:0]  hwdata_i,
    input  logic                                      ap_reg_rd_i,
    input  logic [ahb_mbox_pkg::mbox_region_bit-1:0]  ap_reg_off_i,
    output logic [ahb_mbox_pkg::mbox_data_width-1:0]  reg_rdata_o,
    output logic                                      irq_o
);

import ahb_mbox_pkg::*;

localparam logic [mbox_region_bit-1:0] OFF_CTRL0 = 'h00;
localparam logic [mbox_region_bit-1:0] OFF_CTRL1 = 'h04;

mbox_ctrl_u ctrl0_q;
mbox_ctrl_u ctrl1_q;

logic wr_en;
logic fwd;

assign wr_en = dp_valid_i && dp_write_i && !dp_ram_i && !dp_err_i;
assign fwd   = wr_en && (dp_reg_off_i == ap_reg_off_i);

always_ff @(posedge hclk_i or negedge hresetn_i) begin
    if (!hresetn_i) begin
        ctrl0_q <= '0;
        ctrl1_q <= '0;
    end else if (wr_en) begin
        case (dp_reg_off_i)
            OFF_CTRL0: begin
                ctrl0_q.raw <= hwdata_i;
            end
            OFF_CTRL1: begin
                ctrl1_q.raw <= hwdata_i;
            end
            default: begin
            end
        endcase
    end
end

always_ff @(posedge hclk_i) begin
    if (ap_reg_rd_i) begin
        case (ap_reg_off_i)
            OFF_CTRL0: begin
                reg_rdata_o <= fwd ? hwdata_i : ctrl0_q.raw;
            end
            OFF_CTRL1: begin
                reg_rdata_o <= fwd ? hwdata_i : ctrl1_q.raw;
            end
            default: begin
                reg_rdata_o <= '0;  // Unmapped offset
            end
        endcase
    end
end

// Either side raising its interrupt flag signals the other one
always_ff @(posedge hclk_i or negedge hresetn_i) begin
    if (!hresetn_i) begin
        irq_o <= 1'b0;
    end else begin
        irq_o <= ctrl0_q.f.intr || ctrl1_q.f.intr;
    end
end

endmodule

// ==== verilog/ahb_mbox_ram.sv ====
// Shared message RAM of the mailbox, one word per location
// Writes land at the end of the data phase, reads are taken in the address
// phase so the word is on the bus in the next cycle
`timescale 1ns/1ps

module ahb_mbox_ram #(
    parameter int RAM_DEPTH = 8192
) (
    input  logic                                      hclk_i,
    input  logic                                      dp_valid_i,
    input  logic                                      dp_write_i,
    input  logic                                      dp_ram_i,
    input  logic                                      dp_err_i,
    input  logic [ahb_mbox_pkg::mbox_word_aw-1:0]     dp_word_addr_i,
    input  logic [ahb_mbox_pkg::mbox_data_width-1:0]  hwdata_i,
    input  logic                                      ap_ram_rd_i,
    input  logic [ahb_mbox_pkg::mbox_word_aw-1:0]     ap_word_addr_i,
    output logic [ahb_mbox_pkg::mbox_data_width-1:0]  ram_rdata_o
);

import ahb_mbox_pkg::*;

localparam int RAM_AW = $clog2(RAM_DEPTH);

logic [mbox_data_width-1:0] mem [RAM_DEPTH];

logic wr_en;
logic fwd;

assign wr_en = dp_valid_i && dp_write_i && dp_ram_i && !dp_err_i;

// A read right behind a write to the same word sees the new data
assign fwd = wr_en && (dp_word_addr_i == ap_word_addr_i);

always_ff @(posedge hclk_i) begin
    if (wr_en) begin
        mem[dp_word_addr_i[RAM_AW-1:0]] <= hwdata_i;
    end
end

always_ff @(posedge hclk_i) begin
    if (ap_ram_rd_i) begin
        ram_rdata_o <= fwd ? hwdata_i : mem[ap_word_addr_i[RAM_AW-1:0]];
    end
end

// The decoder passes the full word index, so a small RAM must never be
// reached with an address above its depth
assert property (@(posedge hclk_i)
    dp_valid_i && dp_ram_i && !dp_err_i |-> dp_word_addr_i < RAM_DEPTH)
    else $error("RAM access beyond RAM_DEPTH");

endmodule

// ==== verilog/ahb_mbox_addr_phase.sv ====
// Address-phase capture for the mailbox slave
// Qualifies each AHB transfer, decodes RAM or register space, raises the
// read strobes in the address phase and registers the data-phase controls
`timescale 1ns/1ps

module ahb_mbox_addr_phase #(
    parameter int A_WIDTH = 32
) (
    input  logic                                      hclk_i,
    input  logic                                      hresetn_i,
    input  logic                                      hsel_i,
    input  logic [A_WIDTH-1:0]                        haddr_i,
    input  logic [1:0]                                htrans_i,
    input  logic [2:0]                                hsize_i,
    input  logic                                      hwrite_i,
    input  logic                                      hready_i,
    output logic                                      ap_ram_rd_o,
    output logic                                      ap_reg_rd_o,
    output logic [ahb_mbox_pkg::mbox_word_aw-1:0]     ap_word_addr_o,
    output logic [ahb_mbox_pkg::mbox_region_bit-1:0]  ap_reg_off_o,
    output logic                                      dp_valid_o,
    output logic                                      dp_write_o,
    output logic                                      dp_ram_o,
    output logic                                      dp_err_o,
    output logic [ahb_mbox_pkg::mbox_word_aw-1:0]     dp_word_addr_o,
    output logic [ahb_mbox_pkg::mbox_region_bit-1:0]  dp_reg_off_o
);

import ahb_mbox_pkg::*;

logic accept;
logic size_ok;
logic is_ram;

// Busy and idle transfers are ignored, as is anything during a stall
assign accept  = hsel_i && hready_i &&
                 (htrans_i == htrans_nonseq || htrans_i == htrans_seq);
assign size_ok = (hsize_i == hsize_word);
assign is_ram  = haddr_i[mbox_region_bit];

// Illegal sizes never read, so storage read data stays untouched
assign ap_ram_rd_o    = accept && size_ok && !hwrite_i && is_ram;
assign ap_reg_rd_o    = accept && size_ok && !hwrite_i && !is_ram;
assign ap_word_addr_o = haddr_i[mbox_region_bit-1:2];
assign ap_reg_off_o   = haddr_i[mbox_region_bit-1:0];

always_ff @(posedge hclk_i or negedge hresetn_i) begin
    if (!hresetn_i) begin
        dp_valid_o <= 1'b0;
        dp_write_o <= 1'b0;
        dp_ram_o   <= 1'b0;
        dp_err_o   <= 1'b0;
    end else begin
        dp_valid_o <= accept;  // Drops during the stalled ERROR cycle
        dp_write_o <= accept && hwrite_i;
        dp_ram_o   <= accept && is_ram;
        dp_err_o   <= accept && !size_ok;
    end
end

always_ff @(posedge hclk_i) begin
    if (accept) begin
        dp_word_addr_o <= ap_word_addr_o;
        dp_reg_off_o   <= ap_reg_off_o;
    end
end

// An ERROR data phase holds hready low for its first cycle, so no new
// transfer, and no write, is captured while the error is being answered
assert property (@(posedge hclk_i) disable iff (!hresetn_i)
    dp_valid_o && dp_err_o |-> !hready_i)
    else $error("Transfer captured behind an ERROR data phase");

endmodule

// ==== verilog/ahb_mbox_pkg.sv ====
// Shared constants and types for the AHB-Lite mailbox slave
// Every mailbox module imports this inside its body and uses scoped
// names in its port list where a width or type is needed there

package ahb_mbox_pkg;

    // Fixed at 32 because the control word layout depends on it
    localparam int mbox_data_width = 32;

    // AHB transfer types
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_busy   = 2'b01;
    localparam logic [1:0] htrans_nonseq = 2'b10;
    localparam logic [1:0] htrans_seq    = 2'b11;

    // AHB-Lite responses
    localparam logic [1:0] hresp_okay  = 2'b00;
    localparam logic [1:0] hresp_error = 2'b01;

    localparam logic [2:0] hsize_word = 3'b010;  // Only legal transfer size

    // Address bit that selects the message RAM (set) or the control registers (clear)
    localparam int mbox_region_bit = 15;

    // Word index width inside one half of the address space
    localparam int mbox_word_aw = mbox_region_bit - 2;

    typedef struct packed {
        logic        intr;  // Raises irq_o while set
        logic        full;  // Set while a message waits to be taken
        logic [6:0]  rsvd;
        logic [14:0] size;  // Message size in bytes
        logic [7:0]  id;
    } mbox_ctrl_s;

    // The bus sees a raw word, the interrupt logic sees the fields
    typedef union packed {
        logic [mbox_data_width-1:0] raw;
        mbox_ctrl_s                 f;
    } mbox_ctrl_u;

endpackage
